/* design/rename_defs.svh */
// Sizes must stay powers of two; NUM_PHYS_REGS has to exceed NUM_ISA_REGS by at least one
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Architectural registers, x0 included
`define NUM_ISA_REGS 32

// Physical registers
// Low NUM_ISA_REGS of them hold the identity map at reset
// The rest start in the free list
`define NUM_PHYS_REGS 64

// Copies of the speculative map
// One copy is always live, so NUM_CHECKPOINTS-1 branches can be pending
`define NUM_CHECKPOINTS 4

`endif

/* design/rename_pkg.sv */
// Field widths derive from rename_defs.svh; struct layouts are shared with the testbench
`include "rename_defs.svh"

package rename_pkg;

    typedef logic [$clog2(`NUM_ISA_REGS)-1:0]    reg_t;            // Architectural index
    typedef logic [$clog2(`NUM_PHYS_REGS)-1:0]   phreg_t;          // Physical index
    typedef logic [$clog2(`NUM_CHECKPOINTS)-1:0] checkpoint_ptr_t; // Checkpoint label
    typedef logic [$clog2(`NUM_CHECKPOINTS):0]   ckpt_cnt_t;       // Pending checkpoints

    // One instruction entering rename
    typedef struct packed {
        logic   valid;
        reg_t   src1;
        reg_t   src2;
        reg_t   dst;
        logic   has_dst;
        logic   checkpoint;     // Branch, snapshot after renaming
    } rename_req_t;

    // Renamed instruction, one cycle after acceptance
    typedef struct packed {
        logic            valid;
        phreg_t          src1;
        logic            rdy1;
        phreg_t          src2;
        logic            rdy2;
        phreg_t          new_dst;
        phreg_t          old_dst;      // Freed when this instruction commits
        checkpoint_ptr_t checkpoint;
    } rename_resp_t;

    typedef struct packed {
        logic   valid;
        reg_t   vreg;
        phreg_t preg;
    } wb_t;

    typedef struct packed {
        logic   valid;
        logic   has_dst;
        reg_t   dst;
        phreg_t new_dst;
        phreg_t old_dst;
    } commit_t;

    typedef struct packed {
        logic            valid;
        checkpoint_ptr_t checkpoint;
    } recover_t;

endpackage

/* design/rename_table.sv */
// Caller blocks write and checkpoint during recovery; exception-cycle commits are dropped
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_table import rename_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,                // Async, active low

    input  reg_t            src1_i,
    input  reg_t            src2_i,
    input  reg_t            dst_i,                 // Also looked up for old_dst_o
    input  logic            write_i,               // Map dst_i to new_dst_i, never x0
    input  phreg_t          new_dst_i,
    input  logic            read_i,                // Capture the lookup this edge
    input  logic            checkpoint_i,          // Snapshot after this rename

    input  wb_t             wb1_i,
    input  wb_t             wb2_i,
    input  commit_t         commit_i,
    input  recover_t        recover_i,
    input  logic            delete_checkpoint_i,   // Oldest branch resolved
    input  logic            exception_i,

    output phreg_t          src1_o,
    output phreg_t          src2_o,
    output phreg_t          old_dst_o,
    output logic            rdy1_o,
    output logic            rdy2_o,
    output checkpoint_ptr_t checkpoint_o,          // Label of the copy taken for a branch
    output logic            out_of_checkpoints_o
);

    phreg_t                   map_q [`NUM_CHECKPOINTS][`NUM_ISA_REGS];
    logic [`NUM_ISA_REGS-1:0] rdy_q [`NUM_CHECKPOINTS];
    phreg_t                   commit_map_q [`NUM_ISA_REGS];   // Non-speculative map

    checkpoint_ptr_t head_q;        // Live copy
    checkpoint_ptr_t tail_q;        // Oldest pending checkpoint
    checkpoint_ptr_t head_nxt;
    checkpoint_ptr_t tail_nxt;
    ckpt_cnt_t       cnt_q;
    logic            ckpt_en;
    logic            commit_wr;

    // Write-back landing on this mapping in the current cycle
    function automatic logic wb_hit(input reg_t areg, input phreg_t preg);
        wb_hit = (wb1_i.valid && (wb1_i.vreg == areg) && (wb1_i.preg == preg)) ||
                 (wb2_i.valid && (wb2_i.vreg == areg) && (wb2_i.preg == preg));
    endfunction

    assign head_nxt = head_q + checkpoint_ptr_t'(1);
    assign tail_nxt = tail_q + checkpoint_ptr_t'(delete_checkpoint_i);

    assign out_of_checkpoints_o = (cnt_q == ckpt_cnt_t'(`NUM_CHECKPOINTS - 1));

    // Recovery and exception own the cycle
    assign ckpt_en = checkpoint_i & ~out_of_checkpoints_o & ~recover_i.valid & ~exception_i;

    // x0 stays hardwired in the committed map
    assign commit_wr = commit_i.valid & commit_i.has_dst & (commit_i.dst != '0) & ~exception_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                for (int i = 0; i < `NUM_ISA_REGS; i++) begin
                    map_q[c][i] <= phreg_t'(i);    // Identity
                end
                rdy_q[c] <= '1;
            end
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else if (exception_i) begin
            // Committed state back into copy 0, nothing in flight
            for (int i = 0; i < `NUM_ISA_REGS; i++) begin
                map_q[0][i] <= commit_map_q[i];
            end
            rdy_q[0] <= '1;
            head_q   <= '0;
            tail_q   <= '0;
            cnt_q    <= '0;
        end else begin
            // Ready marking across all copies against old contents
            for (int c = 0; c < `NUM_CHECKPOINTS; c++) begin
                if (wb1_i.valid && (map_q[c][wb1_i.vreg] == wb1_i.preg))
                    rdy_q[c][wb1_i.vreg] <= 1'b1;
                if (wb2_i.valid && (map_q[c][wb2_i.vreg] == wb2_i.preg))
                    rdy_q[c][wb2_i.vreg] <= 1'b1;
            end

            tail_q <= tail_nxt;

            if (recover_i.valid) begin
                head_q <= recover_i.checkpoint;    // Younger copies discarded
                cnt_q  <= ckpt_cnt_t'(checkpoint_ptr_t'(recover_i.checkpoint - tail_nxt));
            end else begin
                cnt_q <= cnt_q + ckpt_cnt_t'(ckpt_en) - ckpt_cnt_t'(delete_checkpoint_i);

                // Old head keeps the branch state, new head goes on live
                if (ckpt_en) begin
                    for (int i = 0; i < `NUM_ISA_REGS; i++) begin
                        map_q[head_nxt][i] <= map_q[head_q][i];
                        rdy_q[head_nxt][i] <= rdy_q[head_q][i] |
                                              wb_hit(reg_t'(i), map_q[head_q][i]);
                    end
                    head_q <= head_nxt;
                end

                // Later assignments win over the copy and the ready marking above
                if (write_i) begin
                    map_q[head_q][dst_i] <= new_dst_i;
                    rdy_q[head_q][dst_i] <= 1'b0;    // Not produced yet
                    if (ckpt_en) begin
                        map_q[head_nxt][dst_i] <= new_dst_i;
                        rdy_q[head_nxt][dst_i] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `NUM_ISA_REGS; i++) begin
                commit_map_q[i] <= phreg_t'(i);
            end
        end else if (commit_wr) begin
            commit_map_q[commit_i.dst] <= commit_i.new_dst;
        end
    end

    // Lookup sees the map before this edge's write
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            src1_o       <= map_q[head_q][src1_i];
            rdy1_o       <= rdy_q[head_q][src1_i] | wb_hit(src1_i, map_q[head_q][src1_i]);
            src2_o       <= map_q[head_q][src2_i];
            rdy2_o       <= rdy_q[head_q][src2_i] | wb_hit(src2_i, map_q[head_q][src2_i]);
            old_dst_o    <= map_q[head_q][dst_i];
            checkpoint_o <= head_q;
        end
    end

endmodule

/* design/free_list.sv */
// Never popped when empty; labels track rename_table; exception-cycle commits are dropped
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_list import rename_pkg::*; (
    input  logic     clk_i,
    input  logic     rstn_i,               // Async, active low

    input  logic     alloc_i,              // Pop the head this edge
    output phreg_t   free_reg_o,           // Next register handed out
    output logic     empty_o,

    input  logic     checkpoint_i,         // Save head after this cycle's pop
    input  commit_t  commit_i,
    input  recover_t recover_i,
    input  logic     delete_checkpoint_i,
    input  logic     exception_i
);

    localparam int IDX_W = $clog2(`NUM_PHYS_REGS);

    typedef logic [IDX_W:0] fl_ptr_t;      // Extra bit tells full from empty

    phreg_t          fifo_q [`NUM_PHYS_REGS];
    fl_ptr_t         head_q;
    fl_ptr_t         tail_q;
    fl_ptr_t         commit_head_q;        // Head as seen by committed code
    fl_ptr_t         saved_head_q [`NUM_CHECKPOINTS];
    checkpoint_ptr_t lbl_head_q;           // Same label as the live map copy
    checkpoint_ptr_t lbl_tail_q;
    checkpoint_ptr_t lbl_tail_nxt;
    ckpt_cnt_t       cnt_q;
    logic            ckpt_en;
    logic            push;

    assign free_reg_o = fifo_q[head_q[IDX_W-1:0]];
    assign empty_o    = (head_q == tail_q);

    assign lbl_tail_nxt = lbl_tail_q + checkpoint_ptr_t'(delete_checkpoint_i);

    assign ckpt_en = checkpoint_i & (cnt_q != ckpt_cnt_t'(`NUM_CHECKPOINTS - 1)) &
                     ~recover_i.valid & ~exception_i;

    // Committed writer of a real register frees the one it displaced
    assign push = commit_i.valid & commit_i.has_dst & (commit_i.dst != '0) & ~exception_i;

    // Tail side keeps taking commits through a misprediction
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
                fifo_q[i] <= phreg_t'(`NUM_ISA_REGS + i);   // Upper half only matters
            end
            tail_q        <= fl_ptr_t'(`NUM_PHYS_REGS - `NUM_ISA_REGS);
            commit_head_q <= '0;
        end else if (push) begin
            fifo_q[tail_q[IDX_W-1:0]] <= commit_i.old_dst;
            tail_q        <= tail_q + fl_ptr_t'(1);
            commit_head_q <= commit_head_q + fl_ptr_t'(1);  // Its own pop is now final
        end
    end

    // Head side and checkpoint labels
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q     <= '0;
            lbl_head_q <= '0;
            lbl_tail_q <= '0;
            cnt_q      <= '0;
        end else if (exception_i) begin
            head_q     <= commit_head_q;   // Speculative pops given back
            lbl_head_q <= '0;
            lbl_tail_q <= '0;
            cnt_q      <= '0;
        end else begin
            lbl_tail_q <= lbl_tail_nxt;
            if (recover_i.valid) begin
                head_q     <= saved_head_q[recover_i.checkpoint];
                lbl_head_q <= recover_i.checkpoint;
                cnt_q      <= ckpt_cnt_t'(checkpoint_ptr_t'(recover_i.checkpoint - lbl_tail_nxt));
            end else begin
                if (alloc_i)
                    head_q <= head_q + fl_ptr_t'(1);
                if (ckpt_en)
                    lbl_head_q <= lbl_head_q + checkpoint_ptr_t'(1);
                cnt_q <= cnt_q + ckpt_cnt_t'(ckpt_en) - ckpt_cnt_t'(delete_checkpoint_i);
            end
        end
    end

    // Branch's own pop included in the saved head
    always_ff @(posedge clk_i) begin
        if (ckpt_en)
            saved_head_q[lbl_head_q] <= head_q + fl_ptr_t'(alloc_i);
    end

endmodule

/* design/rename_stage.sv */
// One rename per cycle; no downstream back-pressure, upstream holds req_i while ready_o is low
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,                // Async, active low

    input  rename_req_t  req_i,
    output logic         ready_o,
    output rename_resp_t resp_o,                // Valid one cycle after acceptance

    input  wb_t          wb1_i,
    input  wb_t          wb2_i,
    input  commit_t      commit_i,
    input  recover_t     recover_i,             // Misprediction
    input  logic         delete_checkpoint_i,
    input  logic         exception_i
);

    logic            needs_reg;
    logic            accept;
    logic            alloc;
    logic            take_ckpt;
    logic            fl_empty;
    logic            out_of_ckpts;
    phreg_t          free_reg;
    phreg_t          tbl_src1;
    phreg_t          tbl_src2;
    phreg_t          tbl_old_dst;
    logic            tbl_rdy1;
    logic            tbl_rdy2;
    checkpoint_ptr_t tbl_ckpt;
    logic            resp_valid_q;
    phreg_t          new_dst_q;

    assign needs_reg = req_i.has_dst & (req_i.dst != '0);   // x0 never renamed

    // Stall on missing resources or any recovery this cycle
    assign ready_o = ~((needs_reg & fl_empty) | (req_i.checkpoint & out_of_ckpts) |
                       recover_i.valid | exception_i);

    assign accept    = req_i.valid & ready_o;
    assign alloc     = accept & needs_reg;
    assign take_ckpt = accept & req_i.checkpoint;

    rename_table u_table (
        .clk_i, .rstn_i,
        .src1_i               (req_i.src1),
        .src2_i               (req_i.src2),
        .dst_i                (req_i.dst),
        .write_i              (alloc),
        .new_dst_i            (free_reg),
        .read_i               (accept),
        .checkpoint_i         (take_ckpt),
        .wb1_i, .wb2_i, .commit_i, .recover_i, .delete_checkpoint_i, .exception_i,
        .src1_o               (tbl_src1),
        .src2_o               (tbl_src2),
        .old_dst_o            (tbl_old_dst),
        .rdy1_o               (tbl_rdy1),
        .rdy2_o               (tbl_rdy2),
        .checkpoint_o         (tbl_ckpt),
        .out_of_checkpoints_o (out_of_ckpts)
    );

    free_list u_free_list (
        .clk_i, .rstn_i,
        .alloc_i      (alloc),
        .free_reg_o   (free_reg),
        .empty_o      (fl_empty),
        .checkpoint_i (take_ckpt),
        .commit_i, .recover_i, .delete_checkpoint_i, .exception_i
    );

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            resp_valid_q <= 1'b0;
        else
            resp_valid_q <= accept;
    end

    // Captured alongside the table lookup
    always_ff @(posedge clk_i) begin
        if (accept)
            new_dst_q <= needs_reg ? free_reg : '0;
    end

    assign resp_o = '{valid: resp_valid_q, src1: tbl_src1, rdy1: tbl_rdy1,
                      src2: tbl_src2, rdy2: tbl_rdy2, new_dst: new_dst_q,
                      old_dst: tbl_old_dst, checkpoint: tbl_ckpt};

endmodule

/* verif/rename_tests.svh */
// Tests run in this order and build on the state left by the ones before

// Reset map, r1 to r31 read back as themselves, ready
task automatic test_identity();
    for (int r = 1; r < `NUM_ISA_REGS; r++) begin
        rename_check(reg_t'(r), reg_t'($random(seed)), '0, 1'b0, 1'b0, 1'b0);
    end
endtask

// Allocation order, busy after rename, ready after write-back
task automatic test_allocate();
    reg_t d;
    for (int k = 0; k < 6; k++) begin
        d = reg_t'($random(seed));
        if (d == '0)
            d = reg_t'(k + 1);
        rename_check('0, '0, d, 1'b1, 1'b0, 1'b0);   // Takes the free list head
        rename_check(d, d, '0, 1'b0, 1'b0, 1'b0);    // New mapping, busy
        write_back(k[0], d);                         // Both ports in turn
        rename_check(d, '0, '0, 1'b0, 1'b0, 1'b0);
    end
endtask

task automatic test_x0_dest();
    rename_check(reg_t'(3), reg_t'(4), '0, 1'b1, 1'b0, 1'b0);   // Writes x0, nothing popped
    rename_check('0, '0, reg_t'(7), 1'b1, 1'b0, 1'b0);          // Still the next free one
    rename_check('0, reg_t'(7), '0, 1'b0, 1'b0, 1'b0);          // x0 stays on p0
endtask

// Branch snapshot, wrong path renames, then misprediction
task automatic test_recovery();
    checkpoint_ptr_t lbl;
    lbl = exp_label;
    rename_check(reg_t'(5), '0, reg_t'(9), 1'b1, 1'b1, 1'b0);   // Branch that also writes
    for (int k = 0; k < 4; k++) begin
        rename_check('0, '0, reg_t'(9 + k), 1'b1, 1'b0, 1'b0);
    end
    recover_to(lbl);
    for (int r = 1; r < `NUM_ISA_REGS; r++) begin
        rename_check(reg_t'(r), reg_t'(r), '0, 1'b0, 1'b0, 1'b0);
    end
    rename_check('0, '0, reg_t'(12), 1'b1, 1'b0, 1'b0);         // Reuses the squashed register
endtask

task automatic test_checkpoint_limit();
    for (int k = 0; k < `NUM_CHECKPOINTS - 1; k++) begin
        rename_check(reg_t'(k + 1), '0, '0, 1'b0, 1'b1, 1'b0);
    end
    // Fourth branch waits for a free copy
    rename_check(reg_t'(2), '0, '0, 1'b0, 1'b1, 1'b1);
endtask

// Partial commit, then exception back to the committed state
task automatic test_exception();
    reg_t d;
    for (int k = 0; k < 3; k++) begin
        rename_check('0, '0, reg_t'(20 + k), 1'b1, 1'b0, 1'b0);
    end
    while (log_q.size() > 3)
        commit_oldest();                              // Youngest three stay speculative
    raise_exception();
    for (int r = 1; r < `NUM_ISA_REGS; r++) begin
        rename_check(reg_t'(r), reg_t'(r), '0, 1'b0, 1'b0, 1'b0);
    end
    // Drain past the reset entries into the freed ones
    while (fl_head < `NUM_PHYS_REGS - `NUM_ISA_REGS + 2) begin
        d = reg_t'($random(seed));
        if (d == '0)
            d = reg_t'(1);
        rename_check(reg_t'($random(seed)), d, d, 1'b1, 1'b0, 1'b0);
    end
endtask

/* verif/rename_tb.sv */
// Reference model assumes commits arrive in rename order and only outside exception cycles
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_tb import rename_pkg::*; ();

    logic         clk_i;
    logic         rstn_i;
    rename_req_t  req_i;
    logic         ready_o;
    rename_resp_t resp_o;
    wb_t          wb1_i;
    wb_t          wb2_i;
    commit_t      commit_i;
    recover_t     recover_i;
    logic         delete_checkpoint_i;
    logic         exception_i;

    integer          seed;
    phreg_t          exp_map [`NUM_ISA_REGS];     // Live speculative map
    logic            exp_rdy [`NUM_ISA_REGS];
    phreg_t          cmt_map [`NUM_ISA_REGS];     // Committed map
    phreg_t          fl_q [$];                    // Every register ever queued, oldest first
    int              fl_head;                     // Next pop, index into fl_q
    int              fl_cmt_head;
    checkpoint_ptr_t exp_label;                   // Live map copy
    commit_t         log_q [$];                   // Renames with a register, not yet committed
    phreg_t          snap_map [`NUM_CHECKPOINTS][`NUM_ISA_REGS];
    logic            snap_rdy [`NUM_CHECKPOINTS][`NUM_ISA_REGS];
    int              snap_fl_head [`NUM_CHECKPOINTS];
    int              snap_log_len [`NUM_CHECKPOINTS];

    rename_stage uut (
        .clk_i, .rstn_i, .req_i, .ready_o, .resp_o, .wb1_i, .wb2_i,
        .commit_i, .recover_i, .delete_checkpoint_i, .exception_i
    );

    always #5 clk_i = ~clk_i;    // 100 MHz

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Holds req_i until taken, then collects the response
    task automatic handshake(output rename_resp_t rsp);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            n++;
            if (n > 20)
                abort_run("Timeout: ready_o stayed low, request never accepted");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        req_i <= '0;                             // Taken at this edge
        n = 0;
        @(negedge clk_i);
        while (!resp_o.valid) begin
            n++;
            if (n > 20)
                abort_run("Timeout: no response after an accepted request");
            @(negedge clk_i);
        end
        rsp = resp_o;
    endtask

    // One rename checked against the model; hold stalls it on a full checkpoint set
    task automatic rename_check(input reg_t s1, input reg_t s2, input reg_t d,
                                input logic hd, input logic ck, input logic hold);
        rename_req_t  r;
        rename_resp_t rsp;
        commit_t      entry;
        logic         alloc;
        alloc = hd && (d != '0);                 // x0 never takes a register
        r = '{valid: 1'b1, src1: s1, src2: s2, dst: d, has_dst: hd, checkpoint: ck};
        @(posedge clk_i);
        req_i <= r;
        if (hold) begin
            @(negedge clk_i);
            check("ready_o", 32'(ready_o), 32'h0);
            @(posedge clk_i);
            delete_checkpoint_i <= 1'b1;         // Oldest branch resolved
            @(posedge clk_i);
            delete_checkpoint_i <= 1'b0;
        end
        handshake(rsp);
        check("resp_o.src1", 32'(rsp.src1), 32'(exp_map[s1]));
        check("resp_o.rdy1", 32'(rsp.rdy1), 32'(exp_rdy[s1]));
        check("resp_o.src2", 32'(rsp.src2), 32'(exp_map[s2]));
        check("resp_o.rdy2", 32'(rsp.rdy2), 32'(exp_rdy[s2]));
        check("resp_o.checkpoint", 32'(rsp.checkpoint), 32'(exp_label));
        if (alloc) begin
            check("resp_o.new_dst", 32'(rsp.new_dst), 32'(fl_q[fl_head]));
            check("resp_o.old_dst", 32'(rsp.old_dst), 32'(exp_map[d]));
            entry = '{valid: 1'b1, has_dst: 1'b1, dst: d, new_dst: fl_q[fl_head],
                      old_dst: exp_map[d]};
            log_q.push_back(entry);
            exp_map[d] = fl_q[fl_head];
            exp_rdy[d] = 1'b0;
            fl_head++;
        end
        if (ck) begin
            // Snapshot includes this instruction's own rename
            for (int i = 0; i < `NUM_ISA_REGS; i++) begin
                snap_map[exp_label][i] = exp_map[i];
                snap_rdy[exp_label][i] = exp_rdy[i];
            end
            snap_fl_head[exp_label] = fl_head;
            snap_log_len[exp_label] = log_q.size();
            exp_label = checkpoint_ptr_t'(exp_label + 1);
        end
    endtask

    task automatic write_back(input logic port2, input reg_t areg);
        wb_t w;
        w = '{valid: 1'b1, vreg: areg, preg: exp_map[areg]};
        @(posedge clk_i);
        if (port2)
            wb2_i <= w;
        else
            wb1_i <= w;
        @(posedge clk_i);
        wb1_i <= '0;
        wb2_i <= '0;
        exp_rdy[areg] = 1'b1;
    endtask

    task automatic commit_oldest();
        commit_t c;
        c = log_q.pop_front();
        @(posedge clk_i);
        commit_i <= c;
        @(posedge clk_i);
        commit_i <= '0;
        cmt_map[c.dst] = c.new_dst;
        fl_q.push_back(c.old_dst);               // Displaced register back at the tail
        fl_cmt_head++;
    endtask

    task automatic recover_to(input checkpoint_ptr_t lbl);
        @(posedge clk_i);
        recover_i <= '{valid: 1'b1, checkpoint: lbl};
        @(posedge clk_i);
        recover_i <= '0;
        for (int i = 0; i < `NUM_ISA_REGS; i++) begin
            exp_map[i] = snap_map[lbl][i];
            exp_rdy[i] = snap_rdy[lbl][i];
        end
        fl_head = snap_fl_head[lbl];
        while (log_q.size() > snap_log_len[lbl])
            log_q.delete(log_q.size() - 1);      // Squashed renames
        exp_label = lbl;
    endtask

    task automatic raise_exception();
        @(posedge clk_i);
        exception_i <= 1'b1;
        @(posedge clk_i);
        exception_i <= 1'b0;
        for (int i = 0; i < `NUM_ISA_REGS; i++) begin
            exp_map[i] = cmt_map[i];
            exp_rdy[i] = 1'b1;
        end
        fl_head = fl_cmt_head;
        log_q.delete();
        exp_label = '0;
    endtask

`include "rename_tests.svh"

    initial begin
        seed                = 32'h8f61;
        clk_i               = 1'b0;
        rstn_i              = 1'b0;
        req_i               = '0;
        wb1_i               = '0;
        wb2_i               = '0;
        commit_i            = '0;
        recover_i           = '0;
        delete_checkpoint_i = 1'b0;
        exception_i         = 1'b0;
        // Reset state: identity map, all ready, upper registers free in order
        for (int i = 0; i < `NUM_ISA_REGS; i++) begin
            exp_map[i] = phreg_t'(i);
            exp_rdy[i] = 1'b1;
            cmt_map[i] = phreg_t'(i);
        end
        for (int i = `NUM_ISA_REGS; i < `NUM_PHYS_REGS; i++)
            fl_q.push_back(phreg_t'(i));
        fl_head     = 0;
        fl_cmt_head = 0;
        exp_label   = '0;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;

        test_identity();
        test_allocate();
        test_x0_dest();
        test_recovery();
        test_checkpoint_limit();
        test_exception();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
+incdir+verif
design/rename_pkg.sv
design/rename_table.sv
design/free_list.sv
design/rename_stage.sv
verif/rename_tb.sv

/* Makefile */
.PHONY: sim clean

# Exit status of the binary is the test result
sim:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module rename_tb \
		-Mdir obj_dir -o rename_sim
	./obj_dir/rename_sim

clean:
	rm -rf obj_dir
